// File: periph_params.svh
// ------------------------------------------------
// Fixed address map and sizes of the subsystem
// Each peripheral window is 256 bytes, 0x300 and up is unmapped
// ------------------------------------------------
`ifndef PERIPH_PARAMS_SVH
`define PERIPH_PARAMS_SVH

`define PERIPH_GPIO_W 8
`define PERIPH_N_EXT 4
// Source 0 tied low, 1 GPIO, 2 timer, 3 and up external lines
`define PERIPH_N_SRC 7

`define PERIPH_GPIO_BASE 32'h0000_0000
`define PERIPH_TMR_BASE 32'h0000_0100
`define PERIPH_IRQ_BASE 32'h0000_0200
`define PERIPH_WIN_MASK 32'hFFFF_FF00
`define PERIPH_ERR_DATA 32'hBADCAB1E

`endif

// File: periph_pkg.sv
// ------------------------------------------------
// Bus and register access types for the subsystem
// Full-word accesses only, no byte enables
// ------------------------------------------------
`default_nettype none

package periph_pkg;

  typedef enum logic [1:0] {
    REG_READ  = 2'd0,
    REG_WRITE = 2'd1
  } reg_op_e;

  typedef enum logic [1:0] {
    SEL_GPIO = 2'd0,
    SEL_TMR  = 2'd1,
    SEL_IRQ  = 2'd2,
    SEL_NONE = 2'd3
  } periph_sel_e;

  typedef struct packed {
    logic        req;
    logic        we;
    logic [31:0] addr;
    logic [31:0] wdata;
  } bus_req_t;

  typedef struct packed {
    logic        gnt;
    logic        rvalid;
    logic        err;
    logic [31:0] rdata;
  } bus_rsp_t;

  typedef struct packed {
    logic        valid;
    reg_op_e     op;
    logic [7:0]  offset;
    logic [31:0] wdata;
  } reg_req_t;

  typedef struct packed {
    logic [31:0] rdata;
  } reg_rsp_t;

endpackage

`default_nettype wire

// File: obi_to_reg.sv
// ------------------------------------------------
// Grant is always given in the request cycle
// Response valid follows exactly two cycles later, in order
// ------------------------------------------------
`timescale 1ns/1ps
`default_nettype none
`include "periph_params.svh"

module obi_to_reg (
  input  logic                     clk_i,
  input  logic                     arst_n_i,
  input  periph_pkg::bus_req_t     bus_req_i,
  output periph_pkg::bus_rsp_t     bus_rsp_o,
  output periph_pkg::reg_req_t     reg_req_o,
  output periph_pkg::periph_sel_e  sel_o,
  input  periph_pkg::reg_rsp_t     reg_rsp_i
);

  import periph_pkg::*;

  periph_sel_e sel_d;
  periph_sel_e sel_q;
  logic        acc_valid_q;
  reg_op_e     acc_op_q;
  logic [7:0]  acc_off_q;
  logic [31:0] acc_wdata_q;
  logic        rsp_valid_q;
  logic        rsp_err_q;
  logic [31:0] rsp_rdata_q;

  // Window decode on the incoming address
  always_comb begin
    if ((bus_req_i.addr & `PERIPH_WIN_MASK) == `PERIPH_GPIO_BASE) begin
      sel_d = SEL_GPIO;
    end else if ((bus_req_i.addr & `PERIPH_WIN_MASK) == `PERIPH_TMR_BASE) begin
      sel_d = SEL_TMR;
    end else if ((bus_req_i.addr & `PERIPH_WIN_MASK) == `PERIPH_IRQ_BASE) begin
      sel_d = SEL_IRQ;
    end else begin
      sel_d = SEL_NONE;
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      acc_valid_q <= 1'b0;
      rsp_valid_q <= 1'b0;
    end else begin
      acc_valid_q <= bus_req_i.req;
      rsp_valid_q <= acc_valid_q;
    end
  end

  always_ff @(posedge clk_i) begin
    if (bus_req_i.req) begin
      sel_q       <= sel_d;
      acc_op_q    <= bus_req_i.we ? REG_WRITE : REG_READ;
      acc_off_q   <= bus_req_i.addr[7:0];
      acc_wdata_q <= bus_req_i.wdata;
    end
    // Writes return zero data
    if (acc_valid_q) begin
      rsp_err_q   <= (sel_q == SEL_NONE);
      rsp_rdata_q <= (acc_op_q == REG_WRITE) ? 32'h0 : reg_rsp_i.rdata;
    end
  end

  assign reg_req_o = '{valid: acc_valid_q, op: acc_op_q, offset: acc_off_q,
                       wdata: acc_wdata_q};
  assign sel_o = sel_q;

  assign bus_rsp_o = '{gnt: bus_req_i.req, rvalid: rsp_valid_q, err: rsp_err_q,
                       rdata: rsp_rdata_q};

endmodule

`default_nettype wire

// File: reg_xbar.sv
// ------------------------------------------------
// Combinational demux of one register access
// Unmapped accesses read back the error pattern
// ------------------------------------------------
`timescale 1ns/1ps
`default_nettype none
`include "periph_params.svh"

module reg_xbar (
  input  periph_pkg::reg_req_t     reg_req_i,
  input  periph_pkg::periph_sel_e  sel_i,
  output periph_pkg::reg_req_t     gpio_req_o,
  output periph_pkg::reg_req_t     tmr_req_o,
  output periph_pkg::reg_req_t     irq_req_o,
  input  periph_pkg::reg_rsp_t     gpio_rsp_i,
  input  periph_pkg::reg_rsp_t     tmr_rsp_i,
  input  periph_pkg::reg_rsp_t     irq_rsp_i,
  output periph_pkg::reg_rsp_t     reg_rsp_o
);

  import periph_pkg::*;

  // Payload is shared, only valid is steered
  always_comb begin
    gpio_req_o = reg_req_i;
    tmr_req_o  = reg_req_i;
    irq_req_o  = reg_req_i;

    gpio_req_o.valid = reg_req_i.valid && (sel_i == SEL_GPIO);
    tmr_req_o.valid  = reg_req_i.valid && (sel_i == SEL_TMR);
    irq_req_o.valid  = reg_req_i.valid && (sel_i == SEL_IRQ);
  end

  always_comb begin
    case (sel_i)
      SEL_GPIO: begin
        reg_rsp_o = gpio_rsp_i;
      end
      SEL_TMR: begin
        reg_rsp_o = tmr_rsp_i;
      end
      SEL_IRQ: begin
        reg_rsp_o = irq_rsp_i;
      end
      default: begin
        reg_rsp_o.rdata = `PERIPH_ERR_DATA;
      end
    endcase
  end

endmodule

`default_nettype wire

// File: gpio_ctrl.sv
// ------------------------------------------------
// Input changes show in the input register after 2 cycles
// Interrupt state is set on rising input edges, write 1 clears
// ------------------------------------------------
`timescale 1ns/1ps
`default_nettype none
`include "periph_params.svh"

module gpio_ctrl (
  input  logic                      clk_i,
  input  logic                      arst_n_i,
  input  periph_pkg::reg_req_t      reg_req_i,
  output periph_pkg::reg_rsp_t      reg_rsp_o,
  input  logic [`PERIPH_GPIO_W-1:0] gpio_i,
  output logic [`PERIPH_GPIO_W-1:0] gpio_o,
  output logic [`PERIPH_GPIO_W-1:0] gpio_en_o,
  output logic                      intr_o
);

  import periph_pkg::*;

  logic [`PERIPH_GPIO_W-1:0] out_q, oe_q, ie_q;
  logic [`PERIPH_GPIO_W-1:0] sync1_q, sync2_q, prev_q;
  logic [`PERIPH_GPIO_W-1:0] state_q, state_d, state_clr;
  logic                      wr_en;

  assign wr_en = reg_req_i.valid && (reg_req_i.op == REG_WRITE);

  // Edge set wins over a clear in the same cycle
  assign state_clr = (wr_en && reg_req_i.offset == 8'h0C) ?
                     reg_req_i.wdata[`PERIPH_GPIO_W-1:0] : '0;
  assign state_d = (state_q & ~state_clr) | (sync2_q & ~prev_q);

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      out_q   <= '0;
      oe_q    <= '0;
      ie_q    <= '0;
      sync1_q <= '0;
      sync2_q <= '0;
      prev_q  <= '0;
      state_q <= '0;
    end else begin
      sync1_q <= gpio_i;
      sync2_q <= sync1_q;
      prev_q  <= sync2_q;
      state_q <= state_d;
      if (wr_en) begin
        case (reg_req_i.offset)
          8'h00: out_q <= reg_req_i.wdata[`PERIPH_GPIO_W-1:0];
          8'h04: oe_q <= reg_req_i.wdata[`PERIPH_GPIO_W-1:0];
          8'h10: ie_q <= reg_req_i.wdata[`PERIPH_GPIO_W-1:0];
          default: ;
        endcase
      end
    end
  end

  always_comb begin
    reg_rsp_o.rdata = '0;
    case (reg_req_i.offset)
      8'h00: reg_rsp_o.rdata[`PERIPH_GPIO_W-1:0] = out_q;
      8'h04: reg_rsp_o.rdata[`PERIPH_GPIO_W-1:0] = oe_q;
      8'h08: reg_rsp_o.rdata[`PERIPH_GPIO_W-1:0] = sync2_q;
      8'h0C: reg_rsp_o.rdata[`PERIPH_GPIO_W-1:0] = state_q;
      8'h10: reg_rsp_o.rdata[`PERIPH_GPIO_W-1:0] = ie_q;
      default: ;
    endcase
  end

  assign gpio_o    = out_q;
  assign gpio_en_o = oe_q;
  assign intr_o    = |(state_q & ie_q);

endmodule

`default_nettype wire

// File: cmp_timer.sv
// ------------------------------------------------
// Counter wraps to zero on a compare match
// Expired flag stays set until a write of 1 clears it
// ------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module cmp_timer (
  input  logic                 clk_i,
  input  logic                 arst_n_i,
  input  periph_pkg::reg_req_t reg_req_i,
  output periph_pkg::reg_rsp_t reg_rsp_o,
  output logic                 intr_o
);

  import periph_pkg::*;

  logic        cnt_en_q;
  logic [31:0] cnt_q;
  logic [31:0] cmp_q;
  logic        expired_q;
  logic        hit;
  logic        wr_en;

  assign wr_en = reg_req_i.valid && (reg_req_i.op == REG_WRITE);
  assign hit   = cnt_en_q && (cnt_q == cmp_q);

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      cnt_en_q  <= 1'b0;
      cnt_q     <= '0;
      cmp_q     <= '0;
      expired_q <= 1'b0;
    end else begin
      if (hit) begin
        cnt_q <= '0;
      end else if (cnt_en_q) begin
        cnt_q <= cnt_q + 32'd1;
      end
      // Match sets the flag even when cleared in the same cycle
      expired_q <= hit | (expired_q &
                   ~(wr_en && reg_req_i.offset == 8'h0C && reg_req_i.wdata[0]));
      if (wr_en) begin
        case (reg_req_i.offset)
          8'h00: cnt_en_q <= reg_req_i.wdata[0];
          8'h04: cnt_q <= reg_req_i.wdata;
          8'h08: cmp_q <= reg_req_i.wdata;
          default: ;
        endcase
      end
    end
  end

  always_comb begin
    case (reg_req_i.offset)
      8'h00: reg_rsp_o.rdata = {31'h0, cnt_en_q};
      8'h04: reg_rsp_o.rdata = cnt_q;
      8'h08: reg_rsp_o.rdata = cmp_q;
      8'h0C: reg_rsp_o.rdata = {31'h0, expired_q};
      default: reg_rsp_o.rdata = '0;
    endcase
  end

  assign intr_o = expired_q;

endmodule

`default_nettype wire

// File: irq_ctrl.sv
// ------------------------------------------------
// Single target, no priorities, lowest source id wins a claim
// Pending is set by a high source and cleared only by a claim
// ------------------------------------------------
`timescale 1ns/1ps
`default_nettype none
`include "periph_params.svh"

module irq_ctrl (
  input  logic                     clk_i,
  input  logic                     arst_n_i,
  input  periph_pkg::reg_req_t     reg_req_i,
  output periph_pkg::reg_rsp_t     reg_rsp_o,
  input  logic [`PERIPH_N_SRC-1:0] src_i,
  output logic                     irq_o,
  output logic                     msip_o
);

  import periph_pkg::*;

  localparam int unsigned ID_W = $clog2(`PERIPH_N_SRC);

  logic [`PERIPH_N_SRC-1:0] en_q;
  logic [`PERIPH_N_SRC-1:0] pend_q;
  logic [`PERIPH_N_SRC-1:0] claim_mask;
  logic [ID_W-1:0]          claim_id;
  logic                     msip_q;
  logic                     wr_en;
  logic                     claim_rd;

  assign wr_en    = reg_req_i.valid && (reg_req_i.op == REG_WRITE);
  assign claim_rd = reg_req_i.valid && (reg_req_i.op == REG_READ) &&
                    (reg_req_i.offset == 8'h08);

  // Scan downwards so the lowest active id is left
  always_comb begin
    claim_id = '0;
    for (int i = `PERIPH_N_SRC - 1; i > 0; i--) begin
      if (pend_q[i] && en_q[i]) begin
        claim_id = ID_W'(i);
      end
    end
  end

  always_comb begin
    claim_mask = '0;
    if (claim_rd) begin
      claim_mask[claim_id] = 1'b1;
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      en_q   <= '0;
      pend_q <= '0;
      msip_q <= 1'b0;
    end else begin
      // Source 0 never pends
      pend_q <= (pend_q & ~claim_mask) | {src_i[`PERIPH_N_SRC-1:1], 1'b0};
      if (wr_en) begin
        case (reg_req_i.offset)
          8'h00: en_q <= reg_req_i.wdata[`PERIPH_N_SRC-1:0];
          8'h0C: msip_q <= reg_req_i.wdata[0];
          default: ;
        endcase
      end
    end
  end

  always_comb begin
    reg_rsp_o.rdata = '0;
    case (reg_req_i.offset)
      8'h00: reg_rsp_o.rdata[`PERIPH_N_SRC-1:0] = en_q;
      8'h04: reg_rsp_o.rdata[`PERIPH_N_SRC-1:0] = pend_q;
      8'h08: reg_rsp_o.rdata[ID_W-1:0] = claim_id;
      8'h0C: reg_rsp_o.rdata[0] = msip_q;
      default: ;
    endcase
  end

  assign irq_o  = |(pend_q & en_q);
  assign msip_o = msip_q;

endmodule

`default_nettype wire

// File: periph_subsystem.sv
// ------------------------------------------------
// Bridge, crossbar and three register peripherals
// Interrupt source 0 is tied low, see the address map header
// ------------------------------------------------
`timescale 1ns/1ps
`default_nettype none
`include "periph_params.svh"

module periph_subsystem (
  input  logic                      clk_i,
  input  logic                      arst_n_i,
  input  periph_pkg::bus_req_t      bus_req_i,
  output periph_pkg::bus_rsp_t      bus_rsp_o,
  input  logic [`PERIPH_GPIO_W-1:0] gpio_i,
  output logic [`PERIPH_GPIO_W-1:0] gpio_o,
  output logic [`PERIPH_GPIO_W-1:0] gpio_en_o,
  input  logic [`PERIPH_N_EXT-1:0]  ext_irq_i,
  output logic                      irq_o,
  output logic                      msip_o,
  output logic                      tmr_irq_o
);

  import periph_pkg::*;

  reg_req_t                 reg_req;
  reg_rsp_t                 reg_rsp;
  periph_sel_e              sel;
  reg_req_t                 gpio_req, tmr_req, irq_req;
  reg_rsp_t                 gpio_rsp, tmr_rsp, irq_rsp;
  logic                     gpio_intr;
  logic [`PERIPH_N_SRC-1:0] intr_src;

  assign intr_src = {ext_irq_i, tmr_irq_o, gpio_intr, 1'b0};

  obi_to_reg u_bridge (
    .clk_i, .arst_n_i, .bus_req_i, .bus_rsp_o,
    .reg_req_o(reg_req), .sel_o(sel), .reg_rsp_i(reg_rsp)
  );

  reg_xbar u_xbar (
    .reg_req_i(reg_req), .sel_i(sel),
    .gpio_req_o(gpio_req), .tmr_req_o(tmr_req), .irq_req_o(irq_req),
    .gpio_rsp_i(gpio_rsp), .tmr_rsp_i(tmr_rsp), .irq_rsp_i(irq_rsp),
    .reg_rsp_o(reg_rsp)
  );

  gpio_ctrl u_gpio (
    .clk_i, .arst_n_i, .reg_req_i(gpio_req), .reg_rsp_o(gpio_rsp),
    .gpio_i, .gpio_o, .gpio_en_o, .intr_o(gpio_intr)
  );

  cmp_timer u_timer (
    .clk_i, .arst_n_i, .reg_req_i(tmr_req), .reg_rsp_o(tmr_rsp), .intr_o(tmr_irq_o)
  );

  irq_ctrl u_irq (
    .clk_i, .arst_n_i, .reg_req_i(irq_req), .reg_rsp_o(irq_rsp),
    .src_i(intr_src), .irq_o, .msip_o
  );

endmodule

`default_nettype wire

// File: periph_tb_clk.sv
// ------------------------------------------------
// 10 ns clock, reset held low for 10 cycles
// Reset is released on a falling edge
// ------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module periph_tb_clk (
  output logic clk_o,
  output logic arst_n_o
);

  initial begin
    clk_o = 1'b0;
    forever #5 clk_o = ~clk_o;
  end

  initial begin
    arst_n_o = 1'b0;
    repeat (10) @(posedge clk_o);
    @(negedge clk_o);
    arst_n_o = 1'b1;
  end

endmodule

`default_nettype wire

// File: periph_sva.sv
// ------------------------------------------------
// Bus timing and interrupt rules of the subsystem
// Looks at the IRQ controller's pending and enable state
// ------------------------------------------------
`timescale 1ns/1ps
`default_nettype none
`include "periph_params.svh"

module periph_sva (
  input logic                     clk_i,
  input logic                     arst_n_i,
  input periph_pkg::bus_req_t     bus_req_i,
  input periph_pkg::bus_rsp_t     bus_rsp_i,
  input logic [`PERIPH_N_SRC-1:0] pend_i,
  input logic [`PERIPH_N_SRC-1:0] en_i,
  input logic                     irq_i
);

  gnt_follows_req: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    bus_rsp_i.gnt == bus_req_i.req)
    else $error("grant differs from the request strobe");

  // Exactly two cycles, in both directions
  rsp_after_req: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    bus_req_i.req |-> ##2 bus_rsp_i.rvalid)
    else $error("no response valid two cycles after a request");

  rsp_only_after_req: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    bus_rsp_i.rvalid |-> $past(bus_req_i.req, 2))
    else $error("response valid without a request two cycles earlier");

  irq_matches_pending: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    irq_i == (|(pend_i & en_i)))
    else $error("irq_o does not match pending and enable");

endmodule

bind periph_subsystem periph_sva u_sva (
  .clk_i     (clk_i),
  .arst_n_i  (arst_n_i),
  .bus_req_i (bus_req_i),
  .bus_rsp_i (bus_rsp_o),
  .pend_i    (u_irq.pend_q),
  .en_i      (u_irq.en_q),
  .irq_i     (irq_o)
);

`default_nettype wire

// File: periph_tb.sv
// ------------------------------------------------
// Runs the operations of periph_cases.txt against the subsystem
// Inputs change on the falling edge, results are sampled there too
// ------------------------------------------------
`timescale 1ns/1ps
`default_nettype none
`include "periph_params.svh"

module periph_tb;

  import periph_pkg::*;

  localparam int MAX_CASES = 64;

  // First column of the cases file
  localparam logic [31:0] K_END        = 32'd0;
  localparam logic [31:0] K_WRITE      = 32'd1;
  localparam logic [31:0] K_READ       = 32'd2;
  localparam logic [31:0] K_READ_NOWAIT = 32'd3;
  localparam logic [31:0] K_GPIO       = 32'd4;
  localparam logic [31:0] K_EXT        = 32'd5;
  localparam logic [31:0] K_WAIT       = 32'd6;
  localparam logic [31:0] K_PINS       = 32'd7;

  logic                      clk;
  logic                      arst_n;
  bus_req_t                  bus_req;
  bus_rsp_t                  bus_rsp;
  logic [`PERIPH_GPIO_W-1:0] gpio_in;
  logic [`PERIPH_GPIO_W-1:0] gpio_out;
  logic [`PERIPH_GPIO_W-1:0] gpio_en;
  logic [`PERIPH_N_EXT-1:0]  ext_irq;
  logic                      irq;
  logic                      msip;
  logic                      tmr_irq;

  logic [31:0] case_mem [0:4*MAX_CASES-1];
  int unsigned cyc;
  int unsigned limit;
  int unsigned wd_cycles = 0;

  // Outstanding responses, oldest first
  int unsigned due_q[$];
  bus_rsp_t    exp_q[$];
  logic [31:0] addr_q[$];

  periph_tb_clk u_clk (
    .clk_o    (clk),
    .arst_n_o (arst_n)
  );

  periph_subsystem dut (
    .clk_i     (clk),
    .arst_n_i  (arst_n),
    .bus_req_i (bus_req),
    .bus_rsp_o (bus_rsp),
    .gpio_i    (gpio_in),
    .gpio_o    (gpio_out),
    .gpio_en_o (gpio_en),
    .ext_irq_i (ext_irq),
    .irq_o     (irq),
    .msip_o    (msip),
    .tmr_irq_o (tmr_irq)
  );

  task automatic report_fail(input string msg);
    $display("%s", msg);
    $display("=== FAIL ===");
    $fatal(1, "run stopped at the first failure");
  endtask

  function automatic logic is_unmapped(input logic [31:0] addr);
    return addr >= (`PERIPH_IRQ_BASE + 32'h100);
  endfunction

  task automatic check_rsp(input bus_rsp_t got, input bus_rsp_t exp, input logic [31:0] addr);
    if (got !== exp) begin
      report_fail($sformatf({"Error at %0t: addr 0x%08h got gnt=%b rvalid=%b err=%b ",
        "rdata=0x%08h, expected gnt=%b rvalid=%b err=%b rdata=0x%08h"}, $time, addr,
        got.gnt, got.rvalid, got.err, got.rdata, exp.gnt, exp.rvalid, exp.err, exp.rdata));
    end
  endtask

  task automatic check_pins(
    input logic [`PERIPH_GPIO_W-1:0] got_out,
    input logic [`PERIPH_GPIO_W-1:0] exp_out,
    input logic [`PERIPH_GPIO_W-1:0] got_en,
    input logic [`PERIPH_GPIO_W-1:0] exp_en,
    input logic                      got_irq,
    input logic                      exp_irq,
    input logic                      got_msip,
    input logic                      exp_msip,
    input logic                      got_tmr,
    input logic                      exp_tmr
  );
    if ({got_out, got_en, got_irq, got_msip, got_tmr} !==
        {exp_out, exp_en, exp_irq, exp_msip, exp_tmr}) begin
      report_fail($sformatf({"Error at %0t: pins gpio_o=%h gpio_en_o=%h irq=%b msip=%b ",
        "tmr_irq=%b, expected %h %h %b %b %b"}, $time, got_out, got_en, got_irq, got_msip,
        got_tmr, exp_out, exp_en, exp_irq, exp_msip, exp_tmr));
    end
  endtask

  // One clock; checks any response that is due now
  task automatic step();
    bus_rsp_t    exp;
    logic [31:0] addr;
    @(negedge clk);
    cyc++;
    if (due_q.size() > 0 && due_q[0] == cyc) begin
      exp = exp_q.pop_front();
      addr = addr_q.pop_front();
      void'(due_q.pop_front());
      exp.gnt = bus_req.req;
      check_rsp(bus_rsp, exp, addr);
    end else if (bus_rsp.rvalid !== 1'b0) begin
      report_fail($sformatf("Response valid at %0t with no request waiting for it", $time));
    end
  endtask

  task automatic issue(input logic we, input logic [31:0] addr, input logic [31:0] data,
                       input logic [31:0] exp_rdata);
    bus_rsp_t exp;
    exp = '{gnt: 1'b1, rvalid: 1'b1, err: is_unmapped(addr),
            rdata: we ? 32'h0 : exp_rdata};
    bus_req = '{req: 1'b1, we: we, addr: addr, wdata: we ? data : 32'h0};
    due_q.push_back(cyc + 2);
    exp_q.push_back(exp);
    addr_q.push_back(addr);
    step();
    bus_req = '0;
  endtask

  task automatic drain();
    while (due_q.size() != 0) begin
      step();
    end
  endtask

  function automatic int unsigned case_budget();
    int unsigned total;
    int unsigned i;
    total = 50;
    i = 0;
    while (i < MAX_CASES && case_mem[4*i] != K_END) begin
      if (case_mem[4*i] == K_WAIT) begin
        total += case_mem[4*i+2];
      end else begin
        total += 4;
      end
      i++;
    end
    return total;
  endfunction

  always @(posedge clk) begin
    wd_cycles++;
    if (limit != 0 && wd_cycles > limit) begin
      report_fail($sformatf("Timeout after %0d cycles, the case list did not finish", limit));
    end
  end

  initial begin
    int unsigned idx;
    logic [31:0] kind;
    logic [31:0] addr;
    logic [31:0] data;
    logic [31:0] expv;
    bit          done;
    bus_req = '0;
    gpio_in = '0;
    ext_irq = '0;
    cyc = 0;
    limit = 0;
    $readmemh("periph_cases.txt", case_mem);
    limit = case_budget();
    wait (arst_n === 1'b1);

    idx = 0;
    done = 1'b0;
    while (!done) begin
      if (idx >= MAX_CASES) begin
        report_fail("The case list has no end line");
      end
      kind = case_mem[4*idx];
      addr = case_mem[4*idx+1];
      data = case_mem[4*idx+2];
      expv = case_mem[4*idx+3];
      case (kind)
        K_END: begin
          done = 1'b1;
        end
        K_WRITE: begin
          issue(1'b1, addr, data, 32'h0);
          drain();
        end
        K_READ: begin
          issue(1'b0, addr, 32'h0, expv);
          drain();
        end
        K_READ_NOWAIT: begin
          issue(1'b0, addr, 32'h0, expv);
        end
        K_GPIO: begin
          gpio_in = data[`PERIPH_GPIO_W-1:0];
          step();
        end
        K_EXT: begin
          ext_irq = data[`PERIPH_N_EXT-1:0];
          step();
        end
        K_WAIT: begin
          repeat (data) step();
        end
        K_PINS: begin
          check_pins(gpio_out, data[`PERIPH_GPIO_W-1:0],
                     gpio_en, data[2*`PERIPH_GPIO_W-1:`PERIPH_GPIO_W],
                     irq, expv[0], msip, expv[1], tmr_irq, expv[2]);
        end
        default: begin
          report_fail($sformatf("Unknown kind %0h on case line %0d", kind, idx));
        end
      endcase
      idx++;
    end
    drain();
    $display("=== PASS ===");
    $finish;
  end

endmodule

`default_nettype wire

// File: periph_cases.txt
// kind addr data expected, all hex; 1 write, 2 read, 3 read without waiting, 4 gpio_i,
// 5 ext_irq, 6 wait data cycles, 7 pins data={gpio_en,gpio_o} expected={tmr,msip,irq}, 0 end
1 00000200 0000007f 00000000
5 00000000 00000005 00000000
5 00000000 00000000 00000000
6 00000000 00000001 00000000
7 00000000 00000000 00000001
2 00000208 00000000 00000003
2 00000208 00000000 00000005
2 00000208 00000000 00000000
2 00000204 00000000 00000000
7 00000000 00000000 00000000
1 00000000 000000a5 00000000
1 00000004 0000000f 00000000
2 00000000 00000000 000000a5
2 00000004 00000000 0000000f
7 00000000 00000fa5 00000000
4 00000000 0000003c 00000000
6 00000000 00000003 00000000
2 00000008 00000000 0000003c
2 0000000c 00000000 0000003c
1 0000000c 0000003c 00000000
2 0000000c 00000000 00000000
1 00000010 00000001 00000000
4 00000000 0000003d 00000000
6 00000000 00000003 00000000
2 0000000c 00000000 00000001
2 00000204 00000000 00000002
7 00000000 00000fa5 00000001
1 0000000c 00000001 00000000
2 0000000c 00000000 00000000
2 00000208 00000000 00000001
7 00000000 00000fa5 00000000
1 00000108 00000014 00000000
1 00000100 00000001 00000000
6 00000000 0000001e 00000000
2 0000010c 00000000 00000001
7 00000000 00000fa5 00000005
1 00000100 00000000 00000000
1 0000010c 00000001 00000000
2 0000010c 00000000 00000000
7 00000000 00000fa5 00000001
2 00000208 00000000 00000002
7 00000000 00000fa5 00000000
1 0000020c 00000001 00000000
7 00000000 00000fa5 00000002
1 0000020c 00000000 00000000
7 00000000 00000fa5 00000000
2 00000400 00000000 badcab1e
3 00000000 00000000 000000a5
3 00000004 00000000 0000000f
3 00000400 00000000 badcab1e
2 00000108 00000000 00000014
0 00000000 00000000 00000000

// File: build.f
+incdir+.
periph_pkg.sv
obi_to_reg.sv
reg_xbar.sv
gpio_ctrl.sv
cmp_timer.sv
irq_ctrl.sv
periph_subsystem.sv
periph_tb_clk.sv
periph_sva.sv
periph_tb.sv

// File: run.sh
#!/usr/bin/env bash
# Builds the testbench with Verilator and runs it from the project root

cd "$(dirname "$0")"
if [ $? -ne 0 ]; then
  echo "Cannot enter the project directory"
  exit 1
fi

verilator --binary --timing --assert --timescale 1ns/1ps \
  -f build.f --top-module periph_tb -o periph_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/periph_sim
status=$?
if [ $status -ne 0 ]; then
  echo "Simulation failed with status $status"
  exit $status
fi
exit 0
